/* common/rvPkg.sv */
/*
 * Shared types for the multicycle RV32I-subset core.
 * Holds the instruction encodings, the ALU and mux selects, the FSM
 * states and the control-flag bundle between control unit and datapath.
 */
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 codes shared by register and immediate arithmetic
    typedef enum logic [2:0] {
        F3_ADD     = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SRL_SRA = 3'b101,
        F3_AND     = 3'b111
    } funct3_e;

    // selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_SLT,
        ALU_PASSB
    } aluOp_e;

    typedef enum logic {SRCA_PC, SRCA_REGA} aluSrcA_e;
    typedef enum logic [1:0] {SRCB_REGB, SRCB_FOUR, SRCB_IMM, SRCB_BRANCHOFF} aluSrcB_e;
    typedef enum logic {PCSRC_ALU, PCSRC_ALUOUT} pcSrc_e;
    typedef enum logic {WB_ALUOUT, WB_MDR} wbSrc_e;

    typedef struct packed {
        logic     pcWrite;
        logic     pcWriteCond;
        pcSrc_e   pcSrc;
        aluSrcA_e aluSrcA;
        aluSrcB_e aluSrcB;
        aluOp_e   aluOp;
        logic     loadAluOut;
        logic     loadRegA;
        logic     loadRegB;
        logic     loadMdr;
        logic     regWrite;
        wbSrc_e   wbSrc;
        logic     irWrite;
        logic     memAddrData;
        logic     memWrite;
    } ctrlFlags_t;

    // field layout of one instruction word, msb first
    typedef struct packed {
        logic [6:0]  funct7;
        regIdx_t     rs2;
        regIdx_t     rs1;
        logic [2:0]  funct3;
        regIdx_t     rd;
        opcode_e     opcode;
    } instrFields_t;

    typedef enum logic [3:0] {
        ST_FETCH,
        ST_DECODE,
        ST_MEMADDR,
        ST_EXEC_R,
        ST_EXEC_I,
        ST_EXEC_U,
        ST_BRANCH,
        ST_LOAD,
        ST_LOADWAIT,
        ST_STORE,
        ST_WB_ALU,
        ST_WB_MEM
    } cpuState_e;

endpackage

/* datapath/alu.sv */
/*
 * Combinational ALU for the supported RV32I subset.
 * zero flags an all-zero result and drives the beq decision.
 */
`timescale 1ns/1ps

module alu (
    input  rvPkg::word_t  a,
    input  rvPkg::word_t  b,
    input  rvPkg::aluOp_e op,
    output rvPkg::word_t  result,
    output logic          zero
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rvPkg::ALU_ADD:   result = a + b;
            rvPkg::ALU_SUB:   result = a - b;
            rvPkg::ALU_SLL:   result = a << shamt;
            rvPkg::ALU_SRL:   result = a >> shamt;
            rvPkg::ALU_SRA:   result = $signed(a) >>> shamt;
            rvPkg::ALU_AND:   result = a & b;
            rvPkg::ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            rvPkg::ALU_PASSB: result = b;
            default:          result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* datapath/regFile.sv */
/*
 * 32 x 32-bit register file, two asynchronous reads and one
 * synchronous write. x0 always reads zero.
 */
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  rvPkg::regIdx_t rs1,
    input  rvPkg::regIdx_t rs2,
    input  rvPkg::regIdx_t rd,
    input  logic           we,
    input  rvPkg::word_t   wdata,
    output rvPkg::word_t   rdata1,
    output rvPkg::word_t   rdata2
);

    rvPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // entry 0 is never written, so mask it on read
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* datapath/datapath.sv */
/*
 * Datapath of the multicycle core: pc, instruction register, operand and
 * result registers, immediate generation and the operand muxes.
 * Driven cycle by cycle by the control flags; also produces the
 * register-write report and the pc of the instruction in flight.
 */
`timescale 1ns/1ps

module datapath #(
    parameter  int          MEM_WORDS = 256,
    parameter  rvPkg::word_t RESET_PC = '0,
    localparam int          ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic                clk,
    input  logic                rst,
    input  rvPkg::ctrlFlags_t   flags,
    input  rvPkg::word_t        memRdata,
    output logic [ADDR_W-1:0]   memAddr,
    output rvPkg::word_t        memWdata,
    output logic                memWe,
    output rvPkg::instrFields_t instr,
    output logic                zero,
    output logic                wbValid,
    output rvPkg::regIdx_t      wbRd,
    output rvPkg::word_t        wbData,
    output rvPkg::word_t        pc
);

    rvPkg::word_t pcReg;
    rvPkg::word_t irReg;
    rvPkg::word_t irWord;
    rvPkg::word_t regA;
    rvPkg::word_t regB;
    rvPkg::word_t aluOut;
    rvPkg::word_t mdr;
    rvPkg::word_t rdata1;
    rvPkg::word_t rdata2;
    rvPkg::word_t srcA;
    rvPkg::word_t srcB;
    rvPkg::word_t aluResult;
    rvPkg::word_t immI;
    rvPkg::word_t immS;
    rvPkg::word_t immB;
    rvPkg::word_t immU;
    rvPkg::word_t immSel;
    rvPkg::word_t wdata;

    // in decode the fetched word is still on the memory output
    assign irWord = flags.irWrite ? memRdata : irReg;
    assign instr  = irWord;

    assign immI = {{20{irWord[31]}}, irWord[31:20]};
    assign immS = {{20{irWord[31]}}, irWord[31:25], irWord[11:7]};
    assign immB = {{19{irWord[31]}}, irWord[31], irWord[7], irWord[30:25],
                   irWord[11:8], 1'b0};
    assign immU = {irWord[31:12], 12'b0};

    always_comb begin
        case (instr.opcode)
            rvPkg::OP_STORE: immSel = immS;
            rvPkg::OP_LUI:   immSel = immU;
            default:         immSel = immI;
        endcase
    end

    assign srcA = (flags.aluSrcA == rvPkg::SRCA_PC) ? pcReg : regA;

    always_comb begin
        case (flags.aluSrcB)
            rvPkg::SRCB_REGB: srcB = regB;
            rvPkg::SRCB_FOUR: srcB = 32'd4;
            rvPkg::SRCB_IMM:  srcB = immSel;
            // pc has already advanced by 4 when decode runs
            default:          srcB = immB - 32'd4;
        endcase
    end

    alu aluInst (
        .a      (srcA),
        .b      (srcB),
        .op     (flags.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    assign wdata = (flags.wbSrc == rvPkg::WB_MDR) ? mdr : aluOut;

    regFile regFileInst (
        .clk    (clk),
        .rs1    (instr.rs1),
        .rs2    (instr.rs2),
        .rd     (instr.rd),
        .we     (flags.regWrite),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= RESET_PC;
        end else if (flags.pcWrite || (flags.pcWriteCond && zero)) begin
            pcReg <= (flags.pcSrc == rvPkg::PCSRC_ALU) ? aluResult : aluOut;
        end
    end

    always_ff @(posedge clk) begin
        // only fetch advances pc through the alu
        if (flags.pcWrite && flags.pcSrc == rvPkg::PCSRC_ALU) begin
            pc <= pcReg;
        end
        if (flags.irWrite) begin
            irReg <= memRdata;
        end
        if (flags.loadRegA) begin
            regA <= rdata1;
        end
        if (flags.loadRegB) begin
            regB <= rdata2;
        end
        if (flags.loadAluOut) begin
            aluOut <= aluResult;
        end
        if (flags.loadMdr) begin
            mdr <= memRdata;
        end
    end

    assign memAddr  = flags.memAddrData ? aluOut[ADDR_W+1:2] : pcReg[ADDR_W+1:2];
    assign memWdata = regB;
    assign memWe    = flags.memWrite;

    // x0 writes are dropped by the register file and not reported
    assign wbValid = flags.regWrite && (instr.rd != '0);
    assign wbRd    = instr.rd;
    assign wbData  = wdata;

endmodule

/* source/controlUnit.sv */
/*
 * Multicycle control FSM. Every instruction walks fetch, decode and then
 * a short per-class path; each state drives the datapath flags for one
 * cycle. retire marks the last cycle of each instruction.
 */
`timescale 1ns/1ps

module controlUnit (
    input  logic                clk,
    input  logic                rst,
    input  rvPkg::instrFields_t instr,
    input  logic                zero,
    output rvPkg::ctrlFlags_t   flags,
    output logic                retire
);

    rvPkg::cpuState_e state;
    rvPkg::cpuState_e nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rvPkg::ST_FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        // everything inactive, then raise what the state needs
        flags         = '0;
        flags.pcSrc   = rvPkg::PCSRC_ALU;
        flags.aluSrcA = rvPkg::SRCA_PC;
        flags.aluSrcB = rvPkg::SRCB_REGB;
        flags.aluOp   = rvPkg::ALU_ADD;
        flags.wbSrc   = rvPkg::WB_ALUOUT;
        retire        = 1'b0;
        nextState     = rvPkg::ST_FETCH;

        case (state)
            rvPkg::ST_FETCH: begin
                // memory reads at pc while pc moves on by 4
                flags.pcWrite = 1'b1;
                flags.aluSrcB = rvPkg::SRCB_FOUR;
                nextState     = rvPkg::ST_DECODE;
            end

            rvPkg::ST_DECODE: begin
                // latch ir and operands, speculate the branch target
                flags.irWrite    = 1'b1;
                flags.loadRegA   = 1'b1;
                flags.loadRegB   = 1'b1;
                flags.loadAluOut = 1'b1;
                flags.aluSrcB    = rvPkg::SRCB_BRANCHOFF;
                case (instr.opcode)
                    rvPkg::OP_LOAD, rvPkg::OP_STORE: nextState = rvPkg::ST_MEMADDR;
                    rvPkg::OP_REG:    nextState = rvPkg::ST_EXEC_R;
                    rvPkg::OP_IMM:    nextState = rvPkg::ST_EXEC_I;
                    rvPkg::OP_LUI:    nextState = rvPkg::ST_EXEC_U;
                    rvPkg::OP_BRANCH: nextState = rvPkg::ST_BRANCH;
                    default: begin
                        // an unknown opcode retires with no effect
                        retire = 1'b1;
                    end
                endcase
            end

            rvPkg::ST_MEMADDR: begin
                flags.aluSrcA    = rvPkg::SRCA_REGA;
                flags.aluSrcB    = rvPkg::SRCB_IMM;
                flags.loadAluOut = 1'b1;
                if (instr.opcode == rvPkg::OP_LOAD) begin
                    nextState = rvPkg::ST_LOAD;
                end else begin
                    nextState = rvPkg::ST_STORE;
                end
            end

            rvPkg::ST_EXEC_R: begin
                flags.aluSrcA    = rvPkg::SRCA_REGA;
                flags.loadAluOut = 1'b1;
                case (instr.funct3)
                    rvPkg::F3_ADD: begin
                        flags.aluOp = (instr.funct7 == rvPkg::F7_ALT) ?
                                      rvPkg::ALU_SUB : rvPkg::ALU_ADD;
                    end
                    rvPkg::F3_SLL: flags.aluOp = rvPkg::ALU_SLL;
                    rvPkg::F3_SLT: flags.aluOp = rvPkg::ALU_SLT;
                    rvPkg::F3_AND: flags.aluOp = rvPkg::ALU_AND;
                    default:       flags.aluOp = rvPkg::ALU_ADD;
                endcase
                nextState = rvPkg::ST_WB_ALU;
            end

            rvPkg::ST_EXEC_I: begin
                flags.aluSrcA    = rvPkg::SRCA_REGA;
                flags.aluSrcB    = rvPkg::SRCB_IMM;
                flags.loadAluOut = 1'b1;
                case (instr.funct3)
                    rvPkg::F3_SLL: flags.aluOp = rvPkg::ALU_SLL;
                    rvPkg::F3_SLT: flags.aluOp = rvPkg::ALU_SLT;
                    rvPkg::F3_SRL_SRA: begin
                        // srai carries funct7 in the upper immediate bits
                        flags.aluOp = (instr.funct7 == rvPkg::F7_ALT) ?
                                      rvPkg::ALU_SRA : rvPkg::ALU_SRL;
                    end
                    default: flags.aluOp = rvPkg::ALU_ADD;
                endcase
                nextState = rvPkg::ST_WB_ALU;
            end

            rvPkg::ST_EXEC_U: begin
                flags.aluSrcB    = rvPkg::SRCB_IMM;
                flags.aluOp      = rvPkg::ALU_PASSB;
                flags.loadAluOut = 1'b1;
                nextState        = rvPkg::ST_WB_ALU;
            end

            rvPkg::ST_BRANCH: begin
                // target is already in alu-out and taken when a - b is zero
                flags.aluSrcA     = rvPkg::SRCA_REGA;
                flags.aluOp       = rvPkg::ALU_SUB;
                flags.pcWriteCond = 1'b1;
                flags.pcSrc       = rvPkg::PCSRC_ALUOUT;
                retire            = 1'b1;
            end

            rvPkg::ST_LOAD: begin
                flags.memAddrData = 1'b1;
                nextState         = rvPkg::ST_LOADWAIT;
            end

            rvPkg::ST_LOADWAIT: begin
                // read data arrives one cycle after the address
                flags.loadMdr = 1'b1;
                nextState     = rvPkg::ST_WB_MEM;
            end

            rvPkg::ST_STORE: begin
                flags.memAddrData = 1'b1;
                flags.memWrite    = 1'b1;
                retire            = 1'b1;
            end

            rvPkg::ST_WB_ALU: begin
                flags.regWrite = 1'b1;
                retire         = 1'b1;
            end

            rvPkg::ST_WB_MEM: begin
                flags.regWrite = 1'b1;
                flags.wbSrc    = rvPkg::WB_MDR;
                retire         = 1'b1;
            end

            default: nextState = rvPkg::ST_FETCH;
        endcase

        // pc stays put while the core is held in reset
        if (rst) begin
            flags.pcWrite = 1'b0;
        end
    end

endmodule

/* source/unifiedMemory.sv */
/*
 * Word-addressed memory shared by instructions and data.
 * Read data is registered and appears one cycle after the address.
 * The program-load port takes priority over a core write.
 */
`timescale 1ns/1ps

module unifiedMemory #(
    parameter  int MEM_WORDS = 256,
    localparam int ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  rvPkg::word_t      wdata,
    input  logic              we,
    input  logic              loadValid,
    input  logic [ADDR_W-1:0] loadAddr,
    input  rvPkg::word_t      loadData,
    output rvPkg::word_t      rdata
);

    rvPkg::word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (loadValid) begin
            mem[loadAddr] <= loadData;
        end else if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* source/cpuTop.sv */
/*
 * Top level of the multicycle core. A program is written through the
 * load port while rst is high; afterwards every register write and
 * every retired instruction is reported as a one-cycle strobe.
 */
`timescale 1ns/1ps

module cpuTop #(
    parameter  int           MEM_WORDS = 256,
    parameter  rvPkg::word_t RESET_PC  = '0,
    localparam int           ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              loadValid,
    input  logic [ADDR_W-1:0] loadAddr,
    input  rvPkg::word_t      loadData,
    output logic              wbValid,
    output rvPkg::regIdx_t    wbRd,
    output rvPkg::word_t      wbData,
    output logic              retireValid,
    output rvPkg::word_t      retirePc
);

    rvPkg::ctrlFlags_t   flags;
    rvPkg::instrFields_t instr;
    logic                zero;
    logic [ADDR_W-1:0]   memAddr;
    rvPkg::word_t        memWdata;
    logic                memWe;
    rvPkg::word_t        memRdata;

    controlUnit controlUnitInst (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .zero   (zero),
        .flags  (flags),
        .retire (retireValid)
    );

    datapath #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) datapathInst (
        .clk      (clk),
        .rst      (rst),
        .flags    (flags),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .instr    (instr),
        .zero     (zero),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .pc       (retirePc)
    );

    unifiedMemory #(
        .MEM_WORDS (MEM_WORDS)
    ) memoryInst (
        .clk       (clk),
        .addr      (memAddr),
        .wdata     (memWdata),
        .we        (memWe),
        .loadValid (loadValid),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .rdata     (memRdata)
    );

endmodule

/* verification/cpuTop_asserts.sv */
/*
 * Concurrent checks on the report strobes of the core top level.
 * Bound into every cpuTop instance. errorCount lets the testbench
 * notice a failed property.
 */
`timescale 1ns/1ps

module cpuTopAsserts (
    input logic           clk,
    input logic           rst,
    input logic           wbValid,
    input rvPkg::regIdx_t wbRd,
    input logic           retireValid
);

    int unsigned errorCount = 0;

    // no reports while the core is held in reset
    strobesLowInReset: assert property (@(posedge clk) rst |-> !wbValid && !retireValid)
        else begin
            $error("report strobe high while rst is asserted");
            errorCount++;
        end

    // first cycle after reset is a fetch
    strobesLowAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbValid && !retireValid)
        else begin
            $error("report strobe high in the first cycle after reset");
            errorCount++;
        end

    wbRdNotZero: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbRd != '0)
        else begin
            $error("wbValid reported a write to x0");
            errorCount++;
        end

    // shortest instruction (beq) takes three cycles
    retireSpacing: assert property (@(posedge clk) disable iff (rst)
                                    retireValid |=> !retireValid [*2])
        else begin
            $error("retireValid pulses closer than three cycles");
            errorCount++;
        end

endmodule

bind cpuTop cpuTopAsserts strobeChecks (
    .clk         (clk),
    .rst         (rst),
    .wbValid     (wbValid),
    .wbRd        (wbRd),
    .retireValid (retireValid)
);

/* verification/cpuTb.sv */
/*
 * Testbench for the multicycle core. Loads a short program through the
 * load port during reset, runs an instruction-level model next to the
 * DUT and checks every retire and register-write report against it.
 */
`timescale 1ns/1ps

module cpuTb;

    localparam int           MEM_WORDS  = 256;
    localparam int           ADDR_W     = $clog2(MEM_WORDS);
    localparam rvPkg::word_t RESET_PC   = 32'h0;
    localparam int           CLK_PERIOD = 10;
    localparam int           PROG_LEN   = 24;
    localparam rvPkg::word_t HALT_PC    = RESET_PC + 4 * (PROG_LEN - 1);
    // load, idle reset, six cycles per instruction at worst, margin
    localparam int           WATCHDOG_CYCLES = PROG_LEN + 3 + 6 * PROG_LEN + 40;

    logic              clk;
    logic              rst;
    logic              loadValid;
    logic [ADDR_W-1:0] loadAddr;
    rvPkg::word_t      loadData;
    logic              wbValid;
    rvPkg::regIdx_t    wbRd;
    rvPkg::word_t      wbData;
    logic              retireValid;
    rvPkg::word_t      retirePc;

    rvPkg::word_t progWords [PROG_LEN];
    rvPkg::word_t modelRegs [32];
    rvPkg::word_t modelMem [MEM_WORDS];
    rvPkg::word_t modelPc;
    int           cycleCount;
    logic         halted;

    cpuTop #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .wbValid     (wbValid),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .retireValid (retireValid),
        .retirePc    (retirePc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction encoders
    function automatic rvPkg::word_t rType(logic [6:0] f7, rvPkg::regIdx_t rs2,
                                           rvPkg::regIdx_t rs1, logic [2:0] f3,
                                           rvPkg::regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::OP_REG};
    endfunction

    function automatic rvPkg::word_t iType(logic [6:0] opc, logic [11:0] imm,
                                           rvPkg::regIdx_t rs1, logic [2:0] f3,
                                           rvPkg::regIdx_t rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rvPkg::word_t sType(logic [11:0] imm, rvPkg::regIdx_t rs2,
                                           rvPkg::regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::OP_STORE};
    endfunction

    function automatic rvPkg::word_t bType(logic [12:0] imm, rvPkg::regIdx_t rs2,
                                           rvPkg::regIdx_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvPkg::OP_BRANCH};
    endfunction

    function automatic rvPkg::word_t uType(logic [19:0] imm, rvPkg::regIdx_t rd);
        return {imm, rd, rvPkg::OP_LUI};
    endfunction

    task automatic buildProgram();
        rvPkg::word_t r1;
        rvPkg::word_t r2;
        // x1 positive, x2 negative
        r1 = $urandom & 32'h7fff_ffff;
        r2 = $urandom | 32'h8000_0000;
        progWords[0]  = uType(r1[31:12], 1);
        progWords[1]  = iType(rvPkg::OP_IMM, r1[11:0], 1, 3'b000, 1);
        progWords[2]  = uType(r2[31:12], 2);
        progWords[3]  = iType(rvPkg::OP_IMM, r2[11:0], 2, 3'b000, 2);
        progWords[4]  = iType(rvPkg::OP_IMM, 12'd5, 2, 3'b010, 3);
        progWords[5]  = iType(rvPkg::OP_IMM, 12'd7, 1, 3'b001, 4);
        progWords[6]  = iType(rvPkg::OP_IMM, 12'd9, 2, 3'b101, 5);
        progWords[7]  = iType(rvPkg::OP_IMM, 12'h409, 2, 3'b101, 6);
        progWords[8]  = rType(7'b0000000, 2, 1, 3'b000, 7);
        progWords[9]  = rType(7'b0100000, 2, 1, 3'b000, 8);
        progWords[10] = rType(7'b0000000, 2, 1, 3'b001, 9);
        progWords[11] = rType(7'b0000000, 2, 1, 3'b111, 10);
        progWords[12] = rType(7'b0000000, 1, 2, 3'b010, 11);
        progWords[13] = rType(7'b0000000, 2, 1, 3'b010, 12);
        // write to x0, then read it back through add
        progWords[14] = iType(rvPkg::OP_IMM, 12'd5, 1, 3'b000, 0);
        progWords[15] = rType(7'b0000000, 1, 0, 3'b000, 13);
        progWords[16] = iType(rvPkg::OP_IMM, 12'h200, 0, 3'b000, 14);
        progWords[17] = sType(12'd4, 7, 14);
        progWords[18] = iType(rvPkg::OP_LOAD, 12'd4, 14, 3'b010, 15);
        progWords[19] = bType(13'd8, 1, 1);
        progWords[20] = iType(rvPkg::OP_IMM, 12'd99, 0, 3'b000, 16);
        progWords[21] = bType(13'd8, 2, 1);
        progWords[22] = iType(rvPkg::OP_IMM, 12'hfff, 15, 3'b000, 17);
        // self loop marks the end
        progWords[23] = bType(13'd0, 0, 0);
    endtask

    // executes the instruction at modelPc and reports what it should write
    task automatic stepModel(output logic expWrite, output rvPkg::regIdx_t expRd,
                             output rvPkg::word_t expData, output int expCycles);
        rvPkg::word_t ins;
        rvPkg::word_t a;
        rvPkg::word_t b;
        rvPkg::word_t immI;
        rvPkg::word_t immS;
        rvPkg::word_t immB;
        rvPkg::word_t addr;
        rvPkg::word_t res;
        rvPkg::word_t nextPc;
        ins    = modelMem[modelPc[ADDR_W+1:2]];
        expRd  = ins[11:7];
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res    = '0;
        nextPc = modelPc + 4;
        expWrite  = 1'b1;
        expCycles = 4;
        case (ins[6:0])
            rvPkg::OP_REG: begin
                case (ins[14:12])
                    3'b000: res = ins[30] ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = {31'b0, $signed(a) < $signed(b)};
                    default: res = a & b;
                endcase
            end
            rvPkg::OP_IMM: begin
                case (ins[14:12])
                    3'b000: res = a + immI;
                    3'b001: res = a << ins[24:20];
                    3'b010: res = {31'b0, $signed(a) < $signed(immI)};
                    default: begin
                        if (ins[30]) begin
                            res = $signed(a) >>> ins[24:20];
                        end else begin
                            res = a >> ins[24:20];
                        end
                    end
                endcase
            end
            rvPkg::OP_LUI: res = {ins[31:12], 12'b0};
            rvPkg::OP_LOAD: begin
                addr      = a + immI;
                res       = modelMem[addr[ADDR_W+1:2]];
                expCycles = 6;
            end
            rvPkg::OP_STORE: begin
                addr = a + immS;
                modelMem[addr[ADDR_W+1:2]] = b;
                expWrite = 1'b0;
            end
            default: begin
                // only beq is in the program
                if (a == b) begin
                    nextPc = modelPc + immB;
                end
                expWrite  = 1'b0;
                expCycles = 3;
            end
        endcase
        if (expWrite && expRd != '0) begin
            modelRegs[expRd] = res;
        end else begin
            expWrite = 1'b0;
        end
        expData = res;
        modelPc = nextPc;
    endtask

    task automatic stopOnFailure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expectEqual(string name, rvPkg::word_t actual, rvPkg::word_t expected);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            stopOnFailure();
        end
    endtask

    // sampled at the falling edge, where the DUT outputs are settled
    task automatic checkCycle();
        logic           expWrite;
        rvPkg::regIdx_t expRd;
        rvPkg::word_t   expData;
        int             expCycles;
        cycleCount++;
        if (retireValid !== 1'b1) begin
            expectEqual("wbValid", wbValid, 32'd0);
            return;
        end
        if (retirePc === HALT_PC) begin
            halted = 1'b1;
        end
        expectEqual("retirePc", retirePc, modelPc);
        stepModel(expWrite, expRd, expData, expCycles);
        expectEqual("cycles per instruction", cycleCount, expCycles);
        expectEqual("wbValid", wbValid, expWrite);
        if (expWrite) begin
            expectEqual("wbRd", wbRd, expRd);
            expectEqual("wbData", wbData, expData);
        end
        cycleCount = 0;
    endtask

    // bound properties are watched in reset as well as while running
    always @(negedge clk) begin
        if (dut0.strobeChecks.errorCount != 0) begin
            $display("A bound strobe assertion on the DUT failed");
            stopOnFailure();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the program reached its final instruction");
        stopOnFailure();
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        loadValid  = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        cycleCount = 0;
        halted     = 1'b0;
        modelPc    = RESET_PC;
        void'($urandom(32'h303aa46b));
        buildProgram();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        // reset covers the program load and three idle cycles after it
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #1;
            loadValid = 1'b1;
            loadAddr  = RESET_PC[ADDR_W+1:2] + i;
            loadData  = progWords[i];
            modelMem[RESET_PC[ADDR_W+1:2] + i] = progWords[i];
        end
        @(posedge clk);
        #1;
        loadValid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!halted) begin
            @(negedge clk);
            checkCycle();
        end
        if (dut0.strobeChecks.errorCount != 0) begin
            $display("A bound strobe assertion on the DUT failed");
            stopOnFailure();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* src.f */
common/rvPkg.sv
datapath/alu.sv
datapath/regFile.sv
datapath/datapath.sv
source/controlUnit.sv
source/unifiedMemory.sv
source/cpuTop.sv
verification/cpuTop_asserts.sv
verification/cpuTb.sv
